//--- common/vi_pkg.sv
// vi_pkg: shared widths, opcodes, pipeline depths and payload types of the vi_core pipeline
package vi_pkg;

	localparam int XLEN        = 32;
	localparam int REG_ADDR_W  = 5;
	localparam int IMEM_DEPTH  = 64;
	localparam int IMEM_ADDR_W = 6;

	// Depth of the multiply pipe, works from 1 to 5
	localparam int MULT_STAGES = 3;

	// Instruction field layout
	localparam int OPCODE_W = 6;
	localparam int OP_LSB   = 26;
	localparam int RD_LSB   = 21;
	localparam int RA_LSB   = 16;
	localparam int RB_LSB   = 11;
	localparam int IMM_W    = 16;

	typedef logic [XLEN-1:0]       word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	typedef enum logic [OPCODE_W-1:0] {
		OP_NOP  = 6'h00,
		OP_ADD  = 6'h01,
		OP_SUB  = 6'h02,
		OP_AND  = 6'h03,
		OP_OR   = 6'h04,
		OP_XOR  = 6'h05,
		OP_SLT  = 6'h06,
		OP_ADDI = 6'h07,
		OP_LUI  = 6'h08,
		OP_MUL  = 6'h09
	} opcode_e;

	// All-zero word decodes as NOP
	localparam word_t NOP_INSTR = '0;

	// Result competing for the writeback register
	typedef struct packed {
		logic      valid;
		reg_addr_t rd;
		word_t     data;
		word_t     pc;
	} wb_t;

endpackage

//--- common/exec_if.sv
// exec_if: issued instruction from the decode/execute register to the ALU and multiply pipe
`timescale 1ns/1ps

interface exec_if;
	import vi_pkg::*;

	logic      valid;
	opcode_e   op;
	reg_addr_t rd;
	word_t     opa;
	word_t     opb;
	word_t     pc;

	modport issue (
		output valid,
		output op,
		output rd,
		output opa,
		output opb,
		output pc
	);

	modport exec (
		input valid,
		input op,
		input rd,
		input opa,
		input opb,
		input pc
	);

endinterface

//--- hw/fetch.sv
// fetch: program counter, loadable instruction memory and the fetch/decode register
`timescale 1ns/1ps

module fetch (
	input  logic                             clk_i,
	input  logic                             rst_n_i,
	input  logic                             start_i,
	input  logic                             stall_i,
	input  logic                             imem_we_i,
	input  logic [vi_pkg::IMEM_ADDR_W-1:0]   imem_addr_i,
	input  vi_pkg::word_t                    imem_data_i,
	output vi_pkg::word_t                    instr_o,
	output vi_pkg::word_t                    pc_o,
	output logic                             valid_o
);
	import vi_pkg::*;

	word_t                  mem [IMEM_DEPTH];
	logic [IMEM_DEPTH-1:0]  loaded_q;
	logic                   running_q;
	word_t                  pc_q;
	logic [IMEM_ADDR_W-1:0] index;
	logic                   in_range;
	logic                   advance;
	word_t                  fetch_word;
	word_t                  instr_q;
	word_t                  fd_pc_q;
	logic                   valid_q;

	// PC is a byte address, one word per cycle
	assign index      = pc_q[IMEM_ADDR_W+1:2];
	assign in_range   = (pc_q[XLEN-1:IMEM_ADDR_W+2] == '0);
	assign fetch_word = (in_range && loaded_q[index]) ? mem[index] : NOP_INSTR;
	assign advance    = running_q && !stall_i && !start_i;

	always_ff @(posedge clk_i) begin
		if (imem_we_i && !running_q) begin
			mem[imem_addr_i] <= imem_data_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			running_q <= 1'b0;
			pc_q      <= '0;
			loaded_q  <= '0;
			valid_q   <= 1'b0;
		end else begin
			if (imem_we_i && !running_q) begin
				loaded_q[imem_addr_i] <= 1'b1;
			end
			if (start_i) begin
				running_q <= 1'b1;
				pc_q      <= '0;
				valid_q   <= 1'b0;
			end else if (advance) begin
				pc_q    <= pc_q + word_t'(4);
				valid_q <= 1'b1;
			end
		end
	end

	// Fetch/decode register holds while stalled
	always_ff @(posedge clk_i) begin
		if (advance) begin
			instr_q <= fetch_word;
			fd_pc_q <= pc_q;
		end
	end

	assign instr_o = instr_q;
	assign pc_o    = fd_pc_q;
	assign valid_o = valid_q;

endmodule

//--- hw/decoder.sv
// decoder: splits an instruction into opcode, register addresses and extended immediate
`timescale 1ns/1ps

module decoder (
	input  vi_pkg::word_t     instr_i,
	input  logic              valid_i,
	output vi_pkg::opcode_e   op_o,
	output vi_pkg::reg_addr_t ra_o,
	output vi_pkg::reg_addr_t rb_o,
	output vi_pkg::reg_addr_t rd_o,
	output vi_pkg::word_t     imm_o,
	output logic              writes_o
);
	import vi_pkg::*;

	logic [OPCODE_W-1:0] op_field;
	logic [IMM_W-1:0]    imm_field;
	logic                reads_a;
	logic                reads_b;

	assign op_field  = instr_i[OP_LSB +: OPCODE_W];
	assign imm_field = instr_i[IMM_W-1:0];

	always_comb begin
		op_o    = OP_NOP;
		reads_a = 1'b0;
		reads_b = 1'b0;
		if (valid_i) begin
			case (op_field)
				OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_MUL: begin
					op_o    = opcode_e'(op_field);
					reads_a = 1'b1;
					reads_b = 1'b1;
				end
				OP_ADDI: begin
					op_o    = OP_ADDI;
					reads_a = 1'b1;
				end
				OP_LUI: op_o = OP_LUI;
				// Undefined opcodes fall through as NOP
				default: op_o = OP_NOP;
			endcase
		end
	end

	// Unused sources read as r0 so they never match a hazard
	assign ra_o = reads_a ? instr_i[RA_LSB +: REG_ADDR_W] : '0;
	assign rb_o = reads_b ? instr_i[RB_LSB +: REG_ADDR_W] : '0;
	assign rd_o = instr_i[RD_LSB +: REG_ADDR_W];

	assign imm_o = (op_o == OP_LUI) ? {imm_field, {(XLEN-IMM_W){1'b0}}}
	                                : {{(XLEN-IMM_W){imm_field[IMM_W-1]}}, imm_field};

	assign writes_o = (op_o != OP_NOP) && (rd_o != '0);

endmodule

//--- hw/int_registers.sv
// int_registers: 32 x 32-bit integer register file, two read ports, one write port
`timescale 1ns/1ps

module int_registers (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  vi_pkg::reg_addr_t ra_i,
	input  vi_pkg::reg_addr_t rb_i,
	input  logic              we_i,
	input  vi_pkg::reg_addr_t wa_i,
	input  vi_pkg::word_t     wd_i,
	output vi_pkg::word_t     rda_o,
	output vi_pkg::word_t     rdb_o
);
	import vi_pkg::*;

	word_t regs [2**REG_ADDR_W];

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < 2**REG_ADDR_W; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && (wa_i != '0)) begin
			regs[wa_i] <= wd_i;
		end
	end

	// r0 is hardwired to zero
	assign rda_o = (ra_i == '0) ? '0 : regs[ra_i];
	assign rdb_o = (rb_i == '0) ? '0 : regs[rb_i];

endmodule

//--- hw/bypass_ctrl.sv
// bypass_ctrl: operand forwarding and stall generation for multiply hazards and wb collisions
`timescale 1ns/1ps

module bypass_ctrl (
	input  vi_pkg::reg_addr_t                          ra_i,
	input  vi_pkg::reg_addr_t                          rb_i,
	input  vi_pkg::reg_addr_t                          rd_i,
	input  logic                                       writes_i,
	input  logic                                       is_mul_i,
	input  vi_pkg::word_t                              rfa_i,
	input  vi_pkg::word_t                              rfb_i,
	input  vi_pkg::wb_t                                alu_wb_i,
	input  vi_pkg::wb_t                                mul_wb_i,
	input  vi_pkg::reg_addr_t [vi_pkg::MULT_STAGES-1:0] mul_rd_i,
	input  logic [vi_pkg::MULT_STAGES-1:0]             mul_valid_i,
	input  logic                                       ex_mul_i,
	input  vi_pkg::reg_addr_t                          ex_rd_i,
	input  vi_pkg::wb_t                                wb_reg_i,
	output vi_pkg::word_t                              opa_o,
	output vi_pkg::word_t                              opb_o,
	output logic                                       stall_o
);
	import vi_pkg::*;

	logic hazard;
	logic collision;

	// Youngest producer wins
	function automatic word_t forward(input reg_addr_t src, input word_t rf_data);
		word_t value;
		value = rf_data;
		if (src == '0) begin
			value = '0;
		end else if (alu_wb_i.valid && (alu_wb_i.rd == src)) begin
			value = alu_wb_i.data;
		end else if (mul_wb_i.valid && (mul_wb_i.rd == src)) begin
			value = mul_wb_i.data;
		end else if (wb_reg_i.valid && (wb_reg_i.rd == src)) begin
			value = wb_reg_i.data;
		end
		return value;
	endfunction

	// Source or destination clash with a MUL still in flight
	function automatic logic clash(input reg_addr_t mul_rd);
		logic hit;
		hit = ((ra_i != '0) && (ra_i == mul_rd)) ||
		      ((rb_i != '0) && (rb_i == mul_rd)) ||
		      (writes_i && (rd_i == mul_rd));
		return hit;
	endfunction

	assign opa_o = forward(ra_i, rfa_i);
	assign opb_o = forward(rb_i, rfb_i);

	// Stage k of the pipe sits at index k-1, the last stage is forwarded instead
	always_comb begin
		hazard = ex_mul_i && clash(ex_rd_i);
		for (int k = 0; k < MULT_STAGES - 1; k++) begin
			if (mul_valid_i[k] && clash(mul_rd_i[k])) begin
				hazard = 1'b1;
			end
		end
	end

	// An ALU op would reach writeback together with the MUL one stage from the end
	generate
		if (MULT_STAGES == 1) begin : g_coll_ex
			assign collision = writes_i && !is_mul_i && ex_mul_i;
		end else begin : g_coll_pipe
			assign collision = writes_i && !is_mul_i && mul_valid_i[MULT_STAGES-2];
		end
	endgenerate

	assign stall_o = hazard || collision;

endmodule

//--- hw/int_alu.sv
// int_alu: single-cycle integer ALU for all non-multiply opcodes
`timescale 1ns/1ps

module int_alu (
	exec_if.exec        ex,
	output vi_pkg::wb_t result_o
);
	import vi_pkg::*;

	word_t data;

	always_comb begin
		case (ex.op)
			OP_ADD, OP_ADDI: data = ex.opa + ex.opb;
			OP_SUB:          data = ex.opa - ex.opb;
			OP_AND:          data = ex.opa & ex.opb;
			OP_OR:           data = ex.opa | ex.opb;
			OP_XOR:          data = ex.opa ^ ex.opb;
			OP_SLT: begin
				data = {{(XLEN-1){1'b0}}, ($signed(ex.opa) < $signed(ex.opb))};
			end
			// Immediate arrives already shifted into the upper half
			OP_LUI:          data = ex.opb;
			default:         data = '0;
		endcase
	end

	assign result_o.valid = ex.valid && (ex.op != OP_MUL);
	assign result_o.rd    = ex.rd;
	assign result_o.data  = data;
	assign result_o.pc    = ex.pc;

endmodule

//--- hw/mult/mult_pipe.sv
// mult_pipe: multi-stage multiply pipe carrying destination, pc and product to writeback
`timescale 1ns/1ps

module mult_pipe (
	input  logic                                        clk_i,
	input  logic                                        rst_n_i,
	exec_if.exec                                        ex,
	output vi_pkg::reg_addr_t [vi_pkg::MULT_STAGES-1:0] stage_rd_o,
	output logic [vi_pkg::MULT_STAGES-1:0]              stage_valid_o,
	output vi_pkg::wb_t                                 result_o
);
	import vi_pkg::*;

	logic      [MULT_STAGES-1:0] valid_q;
	reg_addr_t [MULT_STAGES-1:0] rd_q;
	word_t     [MULT_STAGES-1:0] pc_q;
	word_t     [MULT_STAGES-1:0] prod_q;
	logic                        take;

	assign take = ex.valid && (ex.op == OP_MUL);

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			valid_q <= '0;
		end else begin
			valid_q <= MULT_STAGES'({valid_q, take});
		end
	end

	// Low half of the product is computed into stage 1, later stages only shift
	always_ff @(posedge clk_i) begin
		prod_q[0] <= ex.opa * ex.opb;
		rd_q[0]   <= ex.rd;
		pc_q[0]   <= ex.pc;
		for (int k = 1; k < MULT_STAGES; k++) begin
			prod_q[k] <= prod_q[k-1];
			rd_q[k]   <= rd_q[k-1];
			pc_q[k]   <= pc_q[k-1];
		end
	end

	assign stage_rd_o    = rd_q;
	assign stage_valid_o = valid_q;

	assign result_o.valid = valid_q[MULT_STAGES-1];
	assign result_o.rd    = rd_q[MULT_STAGES-1];
	assign result_o.data  = prod_q[MULT_STAGES-1];
	assign result_o.pc    = pc_q[MULT_STAGES-1];

endmodule

//--- hw/vi_core.sv
// vi_core: in-order integer pipeline with ALU and multiply paths merged at writeback
`timescale 1ns/1ps

module vi_core (
	input  logic                           clk_i,
	input  logic                           rst_n_i,
	input  logic                           imem_we_i,
	input  logic [vi_pkg::IMEM_ADDR_W-1:0] imem_addr_i,
	input  vi_pkg::word_t                  imem_data_i,
	input  logic                           start_i,
	output logic                           wb_valid_o,
	output vi_pkg::reg_addr_t              wb_rd_o,
	output vi_pkg::word_t                  wb_data_o,
	output vi_pkg::word_t                  wb_pc_o
);
	import vi_pkg::*;

	// Fetch/decode stage
	word_t     fd_instr;
	word_t     fd_pc;
	logic      fd_valid;

	// Decode
	opcode_e   dec_op;
	reg_addr_t dec_ra;
	reg_addr_t dec_rb;
	reg_addr_t dec_rd;
	word_t     dec_imm;
	logic      dec_writes;
	logic      dec_uses_imm;
	word_t     rf_a;
	word_t     rf_b;
	word_t     byp_a;
	word_t     byp_b;
	logic      stall;

	// Execute and writeback
	wb_t                         alu_wb;
	wb_t                         mul_wb;
	reg_addr_t [MULT_STAGES-1:0] mul_stage_rd;
	logic      [MULT_STAGES-1:0] mul_stage_valid;
	logic                        ex_mul;
	wb_t                         wb_next;
	wb_t                         wb_q;

	exec_if ex_bus ();

	fetch u_fetch (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.start_i     (start_i),
		.stall_i     (stall),
		.imem_we_i   (imem_we_i),
		.imem_addr_i (imem_addr_i),
		.imem_data_i (imem_data_i),
		.instr_o     (fd_instr),
		.pc_o        (fd_pc),
		.valid_o     (fd_valid)
	);

	decoder u_decoder (
		.instr_i  (fd_instr),
		.valid_i  (fd_valid),
		.op_o     (dec_op),
		.ra_o     (dec_ra),
		.rb_o     (dec_rb),
		.rd_o     (dec_rd),
		.imm_o    (dec_imm),
		.writes_o (dec_writes)
	);

	int_registers u_int_registers (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.ra_i    (dec_ra),
		.rb_i    (dec_rb),
		.we_i    (wb_q.valid),
		.wa_i    (wb_q.rd),
		.wd_i    (wb_q.data),
		.rda_o   (rf_a),
		.rdb_o   (rf_b)
	);

	assign ex_mul = ex_bus.valid && (ex_bus.op == OP_MUL);

	bypass_ctrl u_bypass_ctrl (
		.ra_i        (dec_ra),
		.rb_i        (dec_rb),
		.rd_i        (dec_rd),
		.writes_i    (dec_writes),
		.is_mul_i    (dec_op == OP_MUL),
		.rfa_i       (rf_a),
		.rfb_i       (rf_b),
		.alu_wb_i    (alu_wb),
		.mul_wb_i    (mul_wb),
		.mul_rd_i    (mul_stage_rd),
		.mul_valid_i (mul_stage_valid),
		.ex_mul_i    (ex_mul),
		.ex_rd_i     (ex_bus.rd),
		.wb_reg_i    (wb_q),
		.opa_o       (byp_a),
		.opb_o       (byp_b),
		.stall_o     (stall)
	);

	assign dec_uses_imm = (dec_op == OP_ADDI) || (dec_op == OP_LUI);

	// Decode/execute register, non-writing instructions and stalls issue a bubble
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			ex_bus.valid <= 1'b0;
		end else begin
			ex_bus.valid <= dec_writes && !stall;
		end
	end

	always_ff @(posedge clk_i) begin
		ex_bus.op  <= dec_op;
		ex_bus.rd  <= dec_rd;
		ex_bus.opa <= byp_a;
		ex_bus.opb <= dec_uses_imm ? dec_imm : byp_b;
		ex_bus.pc  <= fd_pc;
	end

	int_alu u_int_alu (
		.ex       (ex_bus),
		.result_o (alu_wb)
	);

	mult_pipe u_mult_pipe (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.ex            (ex_bus),
		.stage_rd_o    (mul_stage_rd),
		.stage_valid_o (mul_stage_valid),
		.result_o      (mul_wb)
	);

	// Stall rule keeps both paths from arriving in the same cycle
	assign wb_next = mul_wb.valid ? mul_wb : alu_wb;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			wb_q <= '0;
		end else begin
			wb_q <= wb_next;
		end
	end

	assign wb_valid_o = wb_q.valid;
	assign wb_rd_o    = wb_q.rd;
	assign wb_data_o  = wb_q.data;
	assign wb_pc_o    = wb_q.pc;

endmodule

//--- testbench/vi_core_props.sv
// vi_core_props: bound checks on reset state, writeback legality and fetch hold under stall
`timescale 1ns/1ps

module vi_core_props (
	input logic              clk_i,
	input logic              rst_n_i,
	input logic              wb_valid_i,
	input vi_pkg::reg_addr_t wb_rd_i,
	input logic              stall_i,
	input vi_pkg::word_t     fd_instr_i,
	input vi_pkg::word_t     fd_pc_i,
	input logic              fd_valid_i
);

	a_reset_clears_wb: assert property (@(posedge clk_i) !rst_n_i |=> !wb_valid_i)
		else $error("wb_valid_o high in the cycle after reset");

	// r0 writes are filtered in decode
	a_no_r0_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wb_valid_i |-> (wb_rd_i != '0))
		else $error("writeback to r0 seen on the wb port");

	a_stall_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		stall_i |=> ($stable(fd_instr_i) && $stable(fd_pc_i) && $stable(fd_valid_i)))
		else $error("fetch/decode register changed while stalled");

endmodule

bind vi_core vi_core_props u_props (
	.clk_i      (clk_i),
	.rst_n_i    (rst_n_i),
	.wb_valid_i (wb_valid_o),
	.wb_rd_i    (wb_rd_o),
	.stall_i    (stall),
	.fd_instr_i (fd_instr),
	.fd_pc_i    (fd_pc),
	.fd_valid_i (fd_valid)
);

//--- testbench/tb_vi_core.sv
// tb_vi_core: directed tests of the vi_core pipeline against an in-order reference model
`timescale 1ns/1ps

module tb_vi_core;
	import vi_pkg::*;

	localparam int RST_CYCLES  = 4;
	localparam int NUM_TESTS   = 6;
	// Worst case per instruction is one issue slot plus a full multiply stall
	localparam int RUN_CYCLES  = IMEM_DEPTH * (MULT_STAGES + 2) + 2 * MULT_STAGES + 20;
	localparam int CYCLE_LIMIT = NUM_TESTS * (RST_CYCLES + IMEM_DEPTH + 4 + RUN_CYCLES);

	// Opcode mix of the random program, MUL weighted twice, plus one undefined code
	localparam logic [5:0] RAND_OPS [12] = '{
		OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT,
		OP_ADDI, OP_LUI, OP_MUL, OP_MUL, OP_NOP, 6'h3F
	};

	logic                   clk_i;
	logic                   rst_n_i;
	logic                   imem_we_i;
	logic [IMEM_ADDR_W-1:0] imem_addr_i;
	word_t                  imem_data_i;
	logic                   start_i;
	logic                   wb_valid_o;
	reg_addr_t              wb_rd_o;
	word_t                  wb_data_o;
	word_t                  wb_pc_o;

	word_t     prog [IMEM_DEPTH];
	int        prog_len;
	reg_addr_t exp_rd [IMEM_DEPTH];
	word_t     exp_data [IMEM_DEPTH];
	word_t     exp_pc [IMEM_DEPTH];
	logic      exp_used [IMEM_DEPTH];
	int        exp_count;
	word_t     model_regs [32];
	word_t     seen_regs [32];
	int        errors;
	int        tests_run;
	int        tests_failed;
	int        cycles;

	vi_core DUT (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.imem_we_i   (imem_we_i),
		.imem_addr_i (imem_addr_i),
		.imem_data_i (imem_data_i),
		.start_i     (start_i),
		.wb_valid_o  (wb_valid_o),
		.wb_rd_o     (wb_rd_o),
		.wb_data_o   (wb_data_o),
		.wb_pc_o     (wb_pc_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i;
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk_i);
			cycles++;
		end
		$display("Timeout after %0d cycles, the tests did not finish", cycles);
		$display("SOME TESTS FAILED");
		$finish;
	end

	function automatic word_t enc_r(opcode_e op, int rd, int ra, int rb);
		return {op, 5'(rd), 5'(ra), 5'(rb), 11'd0};
	endfunction

	function automatic word_t enc_i(opcode_e op, int rd, int ra, int imm);
		return {op, 5'(rd), 5'(ra), 16'(imm)};
	endfunction

	task automatic emit(input word_t instr);
		prog[prog_len] = instr;
		prog_len++;
	endtask

	task automatic emit_spaced(input word_t instr);
		emit(instr);
		emit(enc_r(OP_NOP, 0, 0, 0));
	endtask

	// In-order execution of the program, one expected write per writing instruction
	task automatic build_model();
		word_t       a;
		word_t       b;
		word_t       res;
		logic [5:0]  op;
		reg_addr_t   rd;
		logic [15:0] imm;
		logic        writes;
		exp_count = 0;
		for (int r = 0; r < 32; r++) begin
			model_regs[r] = '0;
		end
		for (int i = 0; i < prog_len; i++) begin
			op     = prog[i][31:26];
			rd     = prog[i][25:21];
			imm    = prog[i][15:0];
			a      = model_regs[prog[i][20:16]];
			b      = model_regs[prog[i][15:11]];
			writes = (rd != '0);
			case (op)
				OP_ADD:  res = a + b;
				OP_SUB:  res = a - b;
				OP_AND:  res = a & b;
				OP_OR:   res = a | b;
				OP_XOR:  res = a ^ b;
				OP_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				OP_ADDI: res = a + {{16{imm[15]}}, imm};
				OP_LUI:  res = {imm, 16'h0000};
				OP_MUL:  res = a * b;
				default: begin
					res    = '0;
					writes = 1'b0;
				end
			endcase
			if (writes) begin
				model_regs[rd]      = res;
				exp_rd[exp_count]   = rd;
				exp_data[exp_count] = res;
				exp_pc[exp_count]   = 32'(4 * i);
				exp_used[exp_count] = 1'b0;
				exp_count++;
			end
		end
	endtask

	task automatic reset_core();
		@(posedge clk_i);
		rst_n_i   <= 1'b0;
		imem_we_i <= 1'b0;
		start_i   <= 1'b0;
		repeat (RST_CYCLES) @(posedge clk_i);
		rst_n_i <= 1'b1;
	endtask

	task automatic load_and_start();
		for (int i = 0; i < prog_len; i++) begin
			@(posedge clk_i);
			imem_we_i   <= 1'b1;
			imem_addr_i <= IMEM_ADDR_W'(i);
			imem_data_i <= prog[i];
		end
		@(posedge clk_i);
		imem_we_i <= 1'b0;
		start_i   <= 1'b1;
		@(posedge clk_i);
		start_i <= 1'b0;
	endtask

	// Matches a write against the oldest pending write to the same register
	task automatic check_write(input string name, input reg_addr_t rd, input word_t data,
	                           input word_t pc);
		int idx;
		idx = -1;
		for (int i = 0; i < exp_count; i++) begin
			if (idx < 0 && !exp_used[i] && exp_rd[i] == rd) begin
				idx = i;
			end
		end
		seen_regs[rd] = data;
		assert (idx >= 0) else begin
			$display("%s: write of %h to r%0d was not expected", name, data, rd);
			errors++;
		end
		if (idx >= 0) begin
			exp_used[idx] = 1'b1;
			assert (data == exp_data[idx]) else begin
				$display("[ERROR] %s: r%0d data expected %h actual %h", name, rd,
				         exp_data[idx], data);
				errors++;
			end
			assert (pc == exp_pc[idx]) else begin
				$display("[ERROR] %s: r%0d pc expected %h actual %h", name, rd, exp_pc[idx], pc);
				errors++;
			end
		end
	endtask

	task automatic run_test(input string name);
		int seen;
		int waited;
		int limit;
		int errors_before;
		seen          = 0;
		waited        = 0;
		errors_before = errors;
		limit         = prog_len * (MULT_STAGES + 2) + 2 * MULT_STAGES + 20;
		build_model();
		for (int r = 0; r < 32; r++) begin
			seen_regs[r] = '0;
		end
		reset_core();
		load_and_start();
		while (seen < exp_count && waited < limit) begin
			@(negedge clk_i);
			waited++;
			if (wb_valid_o) begin
				check_write(name, wb_rd_o, wb_data_o, wb_pc_o);
				seen++;
			end
		end
		assert (seen == exp_count) else begin
			$display("%s: timed out with %0d of %0d writebacks seen", name, seen, exp_count);
			errors++;
		end
		// A MUL takes MULT_STAGES + 2 cycles from decode to the wb port
		repeat (MULT_STAGES + 2) begin
			@(negedge clk_i);
			assert (!wb_valid_o) else begin
				$display("%s: extra write to r%0d after the last expected one", name, wb_rd_o);
				errors++;
			end
		end
		for (int r = 1; r < 32; r++) begin
			assert (seen_regs[r] == model_regs[r]) else begin
				$display("[ERROR] %s: r%0d final expected %h actual %h", name, r,
				         model_regs[r], seen_regs[r]);
				errors++;
			end
		end
		tests_run++;
		if (errors == errors_before) begin
			$display("[test] %s: ok, %0d writes", name, seen);
		end else begin
			tests_failed++;
			$display("[test] %s: failed with %0d errors", name, errors - errors_before);
		end
	endtask

	task automatic alu_independent();
		prog_len = 0;
		emit_spaced(enc_i(OP_ADDI, 1, 0, 100));
		emit_spaced(enc_i(OP_ADDI, 2, 0, -7));
		emit_spaced(enc_r(OP_ADD, 3, 1, 2));
		emit_spaced(enc_r(OP_SUB, 4, 1, 2));
		emit_spaced(enc_r(OP_AND, 5, 1, 2));
		emit_spaced(enc_r(OP_OR, 6, 1, 2));
		emit_spaced(enc_r(OP_XOR, 7, 1, 2));
		emit_spaced(enc_r(OP_SLT, 8, 2, 1));
		emit_spaced(enc_r(OP_SLT, 9, 1, 2));
		emit_spaced(enc_i(OP_LUI, 10, 0, 16'hABCD));
		run_test("alu_independent");
	endtask

	task automatic alu_forwarding();
		prog_len = 0;
		emit(enc_i(OP_ADDI, 1, 0, 5));
		emit(enc_i(OP_ADDI, 1, 1, 3));
		emit(enc_r(OP_ADD, 2, 1, 1));
		emit(enc_r(OP_SUB, 3, 2, 1));
		emit(enc_r(OP_XOR, 4, 3, 2));
		emit(enc_r(OP_ADD, 5, 4, 3));
		emit(enc_r(OP_SLT, 6, 3, 5));
		emit(enc_r(OP_OR, 7, 6, 5));
		emit(enc_i(OP_ADDI, 7, 7, -100));
		emit(enc_r(OP_AND, 8, 7, 2));
		run_test("alu_forwarding");
	endtask

	task automatic mul_dependent_stall();
		prog_len = 0;
		emit(enc_i(OP_ADDI, 1, 0, 12));
		emit(enc_i(OP_ADDI, 2, 0, -3));
		emit(enc_r(OP_MUL, 3, 1, 2));
		emit(enc_r(OP_ADD, 4, 3, 1));
		emit(enc_r(OP_MUL, 5, 3, 3));
		emit(enc_r(OP_SUB, 6, 5, 4));
		emit(enc_r(OP_MUL, 7, 6, 2));
		emit(enc_r(OP_MUL, 8, 7, 7));
		run_test("mul_dependent_stall");
	endtask

	// Same-rd MUL then ADD, and ALU ops that would meet a MUL at writeback
	task automatic write_order();
		prog_len = 0;
		emit(enc_i(OP_ADDI, 1, 0, 7));
		emit(enc_i(OP_ADDI, 2, 0, 6));
		emit(enc_r(OP_MUL, 3, 1, 2));
		emit(enc_r(OP_ADD, 3, 1, 2));
		emit(enc_r(OP_MUL, 4, 1, 1));
		emit(enc_i(OP_ADDI, 5, 0, 1));
		emit(enc_i(OP_ADDI, 6, 0, 2));
		emit(enc_i(OP_ADDI, 7, 0, 3));
		emit(enc_i(OP_ADDI, 4, 4, 1));
		emit(enc_r(OP_MUL, 9, 2, 2));
		emit(enc_r(OP_NOP, 0, 0, 0));
		emit(enc_i(OP_ADDI, 10, 0, 4));
		emit(enc_i(OP_ADDI, 11, 0, 5));
		emit(enc_r(OP_ADD, 3, 3, 9));
		run_test("write_order");
	endtask

	task automatic zero_register();
		prog_len = 0;
		emit(enc_i(OP_ADDI, 1, 0, 9));
		emit(enc_i(OP_ADDI, 0, 1, 5));
		emit(enc_r(OP_MUL, 0, 1, 1));
		emit(enc_r(OP_ADD, 2, 0, 1));
		emit(enc_r(OP_SUB, 3, 0, 1));
		emit(enc_i(OP_LUI, 0, 0, 16'h1234));
		emit(enc_r(OP_OR, 4, 0, 0));
		emit(enc_i(OP_ADDI, 5, 0, -1));
		emit(enc_r(OP_SLT, 6, 5, 0));
		run_test("zero_register");
	endtask

	task automatic random_program();
		logic [5:0]  op_bits;
		logic [15:0] low;
		prog_len = 0;
		for (int i = 0; i < 40; i++) begin
			op_bits = RAND_OPS[$urandom_range(0, 11)];
			if (op_bits == OP_ADDI || op_bits == OP_LUI) begin
				low = 16'($urandom);
			end else begin
				low = {5'($urandom_range(0, 7)), 11'd0};
			end
			emit({op_bits, 5'($urandom_range(0, 7)), 5'($urandom_range(0, 7)), low});
		end
		run_test("random_program");
	endtask

	initial begin
		rst_n_i      = 1'b0;
		imem_we_i    = 1'b0;
		imem_addr_i  = '0;
		imem_data_i  = '0;
		start_i      = 1'b0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		void'($urandom(3249));
		alu_independent();
		alu_forwarding();
		mul_dependent_stall();
		write_order();
		zero_register();
		random_program();
		$display("Tests run: %0d, tests failed: %0d, failed checks: %0d",
		         tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- run.sh
#!/bin/sh
# Compile and run the vi_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_vi_core -o sim_vi_core \
	&& ./obj_dir/sim_vi_core > sim.log 2>&1 \
	|| { echo "Build or simulation error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "ALL TESTS PASSED" sim.log && exit 0 || exit 1

//--- src.f
common/vi_pkg.sv
common/exec_if.sv
hw/fetch.sv
hw/decoder.sv
hw/int_registers.sv
hw/bypass_ctrl.sv
hw/int_alu.sv
hw/mult/mult_pipe.sv
hw/vi_core.sv
testbench/vi_core_props.sv
testbench/tb_vi_core.sv
